// ==== Bender.yml ====
package:
  name: bp_frontend

sources:
  - bp_config_pkg.sv
  - bp_types_pkg.sv
  - btb.sv
  - bht.sv
  - next_pc_ctrl.sv
  - bp_frontend.sv
  - target: test
    files:
      - bp_frontend_assertions.sv
      - tb_bp_frontend.sv

// ==== bht.sv ====
// Branch history table
// 2-bit saturating counters with the same row and slot geometry as
// the target buffer. Each slot of the row selected by the fetch PC
// reports the counter's upper bit as its taken decision
`timescale 1ns/1ps
`default_nettype none

module bht
  import bp_config_pkg::*;
  import bp_types_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Returns every counter to weakly not-taken
  input  logic                        flush_i,
  // Fetch PC selecting the row
  input  vaddr_t                      vpc_i,
  // Training port from the control block
  input  bht_update_t                 bht_update_i,
  // Predicted direction per slot
  output logic [INSTR_PER_FETCH-1:0]  bht_taken_o
);

  logic [1:0] cnt_q [NR_ROWS][INSTR_PER_FETCH];

  row_idx_t   rd_row;
  row_idx_t   upd_row;
  slot_idx_t  upd_slot;
  logic [1:0] cnt_cur;
  logic [1:0] cnt_nxt;

  assign rd_row   = row_of(vpc_i);
  assign upd_row  = row_of(bht_update_i.pc);
  assign upd_slot = slot_of(bht_update_i.pc);

  // Upper bit set means taken
  for (genvar i = 0; i < INSTR_PER_FETCH; i++) begin : gen_read
    assign bht_taken_o[i] = cnt_q[rd_row][i][1];
  end

  // ---------------------------------------------------------
  // Next counter value for the addressed entry
  // ---------------------------------------------------------
  always_comb begin : cnt_next
    cnt_cur = cnt_q[upd_row][upd_slot];
    cnt_nxt = cnt_cur;
    case (bht_update_i.kind)
      // Jumps are always taken, go straight to strongly taken
      CF_JUMP: cnt_nxt = 2'b11;
      CF_BRANCH: begin
        if (bht_update_i.taken) begin
          if (cnt_cur != 2'b11) cnt_nxt = cnt_cur + 2'd1;
        end else if (cnt_cur != 2'b00) begin
          cnt_nxt = cnt_cur - 2'd1;
        end
      end
      default: cnt_nxt = cnt_cur;
    endcase
  end

  // Flush has priority over training in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int r = 0; r < NR_ROWS; r++) begin
        for (int s = 0; s < INSTR_PER_FETCH; s++) begin
          cnt_q[r][s] <= BHT_INIT;
        end
      end
    end else if (flush_i) begin
      for (int r = 0; r < NR_ROWS; r++) begin
        for (int s = 0; s < INSTR_PER_FETCH; s++) begin
          cnt_q[r][s] <= BHT_INIT;
        end
      end
    end else if (bht_update_i.valid) begin
      cnt_q[upd_row][upd_slot] <= cnt_nxt;
    end
  end

endmodule

`default_nettype wire

// ==== bp_config_pkg.sv ====
// Branch predictor configuration
// Geometry of the target buffer and history table, the shared
// address type and the row and slot index rule of a fetch PC
`default_nettype none

package bp_config_pkg;

  // ---------------------------------------------------------
  // Address space
  // ---------------------------------------------------------
  localparam int unsigned VLEN = 32;
  typedef logic [VLEN-1:0] vaddr_t;

  // First fetch PC after reset and flush
  localparam vaddr_t BOOT_ADDR = 32'h0000_1000;

  // ---------------------------------------------------------
  // Table geometry
  // ---------------------------------------------------------
  // Two 16-bit slots per 4-byte fetch block
  localparam int unsigned INSTR_PER_FETCH = 2;
  localparam int unsigned NR_ENTRIES      = 16;
  localparam int unsigned NR_ROWS         = NR_ENTRIES / INSTR_PER_FETCH;
  localparam int unsigned ROW_BITS        = $clog2(NR_ROWS);
  localparam int unsigned SLOT_BITS       = $clog2(INSTR_PER_FETCH);
  // PC bit 0 is always zero with compressed instructions
  localparam int unsigned OFFSET          = 1;

  // Weakly not-taken start value of every history counter
  localparam logic [1:0] BHT_INIT = 2'b01;

  typedef logic [ROW_BITS-1:0]  row_idx_t;
  typedef logic [SLOT_BITS-1:0] slot_idx_t;

  // Row comes from PC bits 4:2
  function automatic row_idx_t row_of(vaddr_t pc);
    return pc[OFFSET+SLOT_BITS +: ROW_BITS];
  endfunction

  // Slot within the row comes from PC bit 1
  function automatic slot_idx_t slot_of(vaddr_t pc);
    return pc[OFFSET +: SLOT_BITS];
  endfunction

endpackage

`default_nettype wire

// ==== bp_frontend.sv ====
// Branch prediction frontend
// Connects the next-PC control block to the branch target buffer
// and the branch history table
`timescale 1ns/1ps
`default_nettype none

module bp_frontend
  import bp_config_pkg::*;
  import bp_types_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        fetch_en_i,
  input  logic        flush_i,
  input  logic        debug_mode_i,
  input  resolution_t resolve_i,
  output fetch_req_t  fetch_req_o
);

  // Table lookup and training paths
  vaddr_t                                fetch_pc;
  btb_update_t                           btb_update;
  bht_update_t                           bht_update;
  btb_prediction_t [INSTR_PER_FETCH-1:0] btb_pred;
  logic [INSTR_PER_FETCH-1:0]            bht_taken;

  next_pc_ctrl u_next_pc_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .fetch_en_i   (fetch_en_i),
    .flush_i      (flush_i),
    .debug_mode_i (debug_mode_i),
    .resolve_i    (resolve_i),
    .btb_pred_i   (btb_pred),
    .bht_taken_i  (bht_taken),
    .fetch_pc_o   (fetch_pc),
    .btb_update_o (btb_update),
    .bht_update_o (bht_update),
    .fetch_req_o  (fetch_req_o)
  );

  btb u_btb (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .flush_i          (flush_i),
    .vpc_i            (fetch_pc),
    .btb_update_i     (btb_update),
    .btb_prediction_o (btb_pred)
  );

  bht u_bht (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .vpc_i        (fetch_pc),
    .bht_update_i (bht_update),
    .bht_taken_o  (bht_taken)
  );

endmodule

`default_nettype wire

// ==== bp_frontend_assertions.sv ====
// Frontend control assertions
// Bound to the next-PC control block, checks the FSM return to
// idle, that a predicted fetch follows a stored target and that
// the target buffer stays frozen in debug mode
`timescale 1ns/1ps
`default_nettype none

module bp_frontend_assertions
  import bp_config_pkg::*;
  import bp_types_pkg::*;
(
  input logic                                  clk_i,
  input logic                                  rst_ni,
  input logic                                  fetch_en_i,
  input logic                                  flush_i,
  input logic                                  debug_mode_i,
  input fetch_state_e                          state_i,
  input fetch_req_t                            fetch_req_i,
  input vaddr_t                                fetch_pc_i,
  input btb_prediction_t [INSTR_PER_FETCH-1:0] btb_pred_i
);

  // Failures seen so far
  int unsigned fail_count;

  initial fail_count = 0;

  // An edge with enable low leaves the block idle with no request
  a_idle_no_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !fetch_en_i |=> (state_i == ST_IDLE) && !fetch_req_i.valid)
    else begin
      fail_count++;
      $error("fetch request valid in idle state");
    end

  // An enabled predicted fetch continues valid at one of the stored targets
  a_pred_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_req_i.pred_taken && fetch_en_i && !flush_i |=>
      fetch_req_i.valid &&
      (fetch_req_i.pc == $past(btb_pred_i[0].target_address) ||
       fetch_req_i.pc == $past(btb_pred_i[1].target_address)))
    else begin
      fail_count++;
      $error("predicted fetch did not continue at a stored target");
    end

  // Target buffer must not learn in debug mode
  a_no_btb_in_debug: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(debug_mode_i) && !$past(flush_i) && $stable(fetch_pc_i) |->
      $stable(btb_pred_i))
    else begin
      fail_count++;
      $error("btb contents changed in debug mode");
    end

endmodule

bind next_pc_ctrl bp_frontend_assertions u_bp_frontend_assertions (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .fetch_en_i   (fetch_en_i),
  .flush_i      (flush_i),
  .debug_mode_i (debug_mode_i),
  .state_i      (state_q),
  .fetch_req_i  (fetch_req_o),
  .fetch_pc_i   (fetch_pc_o),
  .btb_pred_i   (btb_pred_i)
);

`default_nettype wire

// ==== bp_types_pkg.sv ====
// Branch predictor interface types
// Structs and enums passed between the control block, the two
// predictor tables and the execute stage
`default_nettype none

package bp_types_pkg;
  import bp_config_pkg::*;

  // Kind of resolved control-flow instruction
  typedef enum logic {
    CF_BRANCH = 1'b0,
    CF_JUMP   = 1'b1
  } cf_kind_e;

  // Fetch sequencer states
  typedef enum logic {
    ST_IDLE  = 1'b0,
    ST_FETCH = 1'b1
  } fetch_state_e;

  // ---------------------------------------------------------
  // Execute stage feedback
  // ---------------------------------------------------------
  typedef struct packed {
    logic     valid;
    vaddr_t   pc;
    vaddr_t   target;
    logic     taken;
    logic     mispredict;
    cf_kind_e kind;
  } resolution_t;

  // ---------------------------------------------------------
  // Table write and read ports
  // ---------------------------------------------------------
  typedef struct packed {
    logic   valid;
    vaddr_t pc;
    vaddr_t target_address;
  } btb_update_t;

  typedef struct packed {
    logic   valid;
    vaddr_t target_address;
  } btb_prediction_t;

  typedef struct packed {
    logic     valid;
    vaddr_t   pc;
    logic     taken;
    cf_kind_e kind;
  } bht_update_t;

  // Frontend output toward fetch
  typedef struct packed {
    logic   valid;
    vaddr_t pc;
    logic   pred_taken;
  } fetch_req_t;

endpackage

`default_nettype wire

// ==== btb.sv ====
// Branch target buffer
// Flip-flop table of resolved targets, NR_ROWS rows of one entry
// per 16-bit slot. Both slots of the row selected by the fetch PC
// are presented combinationally. Resolved taken mispredicts write
// one entry; reset and flush drop every entry
`timescale 1ns/1ps
`default_nettype none

module btb
  import bp_config_pkg::*;
  import bp_types_pkg::*;
(
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // Drops every stored target
  input  logic                                   flush_i,
  // Fetch PC selecting the row
  input  vaddr_t                                 vpc_i,
  // Write port from the control block
  input  btb_update_t                            btb_update_i,
  // One entry per slot of the selected row
  output btb_prediction_t [INSTR_PER_FETCH-1:0]  btb_prediction_o
);

  // Entry valid bits, cleared on reset and flush
  logic [INSTR_PER_FETCH-1:0] valid_q [NR_ROWS];
  // Stored targets, meaningful only with the valid bit set
  vaddr_t target_q [NR_ROWS][INSTR_PER_FETCH];

  row_idx_t  rd_row;
  row_idx_t  upd_row;
  slot_idx_t upd_slot;

  assign rd_row   = row_of(vpc_i);
  assign upd_row  = row_of(btb_update_i.pc);
  assign upd_slot = slot_of(btb_update_i.pc);

  // ---------------------------------------------------------
  // Read, zero cycles from the fetch PC
  // ---------------------------------------------------------
  for (genvar i = 0; i < INSTR_PER_FETCH; i++) begin : gen_read
    assign btb_prediction_o[i].valid          = valid_q[rd_row][i];
    assign btb_prediction_o[i].target_address = target_q[rd_row][i];
  end

  // ---------------------------------------------------------
  // Write, visible on the cycle after the update
  // ---------------------------------------------------------
  // Flush wins over an update in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int r = 0; r < NR_ROWS; r++) begin
        valid_q[r] <= '0;
      end
    end else if (flush_i) begin
      for (int r = 0; r < NR_ROWS; r++) begin
        valid_q[r] <= '0;
      end
    end else if (btb_update_i.valid) begin
      valid_q[upd_row][upd_slot] <= 1'b1;
    end
  end

  // Target storage, a write under flush stays hidden behind the cleared valid
  always_ff @(posedge clk_i) begin
    if (btb_update_i.valid) begin
      target_q[upd_row][upd_slot] <= btb_update_i.target_address;
    end
  end

endmodule

`default_nettype wire

// ==== next_pc_ctrl.sv ====
// Next-PC control
// Sequences the fetch PC, picks the predicted next PC from the two
// tables, redirects on a mispredict and turns execute resolutions
// into table updates. Training is held off in debug mode
`timescale 1ns/1ps
`default_nettype none

module next_pc_ctrl
  import bp_config_pkg::*;
  import bp_types_pkg::*;
(
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   fetch_en_i,
  input  logic                                   flush_i,
  input  logic                                   debug_mode_i,
  // Resolution from execute
  input  resolution_t                            resolve_i,
  // Table read results for the current fetch PC
  input  btb_prediction_t [INSTR_PER_FETCH-1:0]  btb_pred_i,
  input  logic [INSTR_PER_FETCH-1:0]             bht_taken_i,
  output vaddr_t                                 fetch_pc_o,
  output btb_update_t                            btb_update_o,
  output bht_update_t                            bht_update_o,
  output fetch_req_t                             fetch_req_o
);

  fetch_state_e state_q, state_d;
  vaddr_t       fetch_pc_q, fetch_pc_d;

  logic   in_fetch;
  logic   mispredict;
  vaddr_t redirect_pc;
  vaddr_t seq_pc;
  logic   pred_hit;
  vaddr_t pred_target;

  assign in_fetch   = (state_q == ST_FETCH);
  assign mispredict = resolve_i.valid && resolve_i.mispredict;

  // Not-taken fallthrough skips one compressed slot
  assign redirect_pc = resolve_i.taken ? resolve_i.target : resolve_i.pc + vaddr_t'(2);
  // Next aligned fetch block
  assign seq_pc      = {fetch_pc_q[VLEN-1:2], 2'b00} + vaddr_t'(4);

  // ---------------------------------------------------------
  // Slot scan, first taken hit at or after the fetch slot
  // ---------------------------------------------------------
  always_comb begin : slot_scan
    pred_hit    = 1'b0;
    pred_target = seq_pc;
    for (int i = 0; i < INSTR_PER_FETCH; i++) begin
      if (!pred_hit && (i >= int'(slot_of(fetch_pc_q))) &&
          btb_pred_i[i].valid && bht_taken_i[i]) begin
        pred_hit    = 1'b1;
        pred_target = btb_pred_i[i].target_address;
      end
    end
  end

  // ---------------------------------------------------------
  // FSM and fetch PC selection
  // ---------------------------------------------------------
  always_comb begin : fsm
    state_d    = state_q;
    fetch_pc_d = fetch_pc_q;
    case (state_q)
      ST_IDLE:  if (fetch_en_i) state_d = ST_FETCH;
      ST_FETCH: if (!fetch_en_i) state_d = ST_IDLE;
      default:  state_d = ST_IDLE;
    endcase
    // Redirect beats flush, flush beats prediction
    if (in_fetch && mispredict) begin
      fetch_pc_d = redirect_pc;
    end else if (flush_i) begin
      fetch_pc_d = BOOT_ADDR;
    end else if (in_fetch && fetch_en_i) begin
      fetch_pc_d = pred_hit ? pred_target : seq_pc;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= ST_IDLE;
      fetch_pc_q <= BOOT_ADDR;
    end else begin
      state_q    <= state_d;
      fetch_pc_q <= fetch_pc_d;
    end
  end

  // ---------------------------------------------------------
  // Outputs
  // ---------------------------------------------------------
  assign fetch_pc_o             = fetch_pc_q;
  assign fetch_req_o.valid      = in_fetch;
  assign fetch_req_o.pc         = fetch_pc_q;
  // Only when the predicted target is the one taken
  assign fetch_req_o.pred_taken = in_fetch && pred_hit && !mispredict;

  // Target buffer learns only taken mispredicts
  assign btb_update_o.valid          = mispredict && resolve_i.taken && !debug_mode_i;
  assign btb_update_o.pc             = resolve_i.pc;
  assign btb_update_o.target_address = resolve_i.target;

  // History table trains on every resolution outside debug
  assign bht_update_o.valid = resolve_i.valid && !debug_mode_i;
  assign bht_update_o.pc    = resolve_i.pc;
  assign bht_update_o.taken = resolve_i.taken;
  assign bht_update_o.kind  = resolve_i.kind;

endmodule

`default_nettype wire

// ==== tb.f ====
bp_config_pkg.sv
bp_types_pkg.sv
btb.sv
bht.sv
next_pc_ctrl.sv
bp_frontend.sv
bp_frontend_assertions.sv
tb_bp_frontend.sv

// ==== tb_bp_frontend.sv ====
// Testbench for the branch prediction frontend
// Seeded random enables, flushes, debug windows and resolutions,
// checked every cycle against a model of both tables and the FSM
`timescale 1ns/1ps
`default_nettype none

module tb_bp_frontend
  import bp_config_pkg::*;
  import bp_types_pkg::*;
();

  localparam int unsigned NUM_CYCLES    = 4000;
  localparam int unsigned START_TIMEOUT = 20;

  logic        clk_i;
  logic        rst_ni;
  logic        fetch_en_i;
  logic        flush_i;
  logic        debug_mode_i;
  resolution_t resolve_i;
  fetch_req_t  fetch_req_o;

  integer seed;
  // Set when the next fetch PC must be the boot address
  logic   boot_check;

  // ------------------------------------------------------------
  // Reference model state
  // ------------------------------------------------------------
  fetch_state_e m_state;
  vaddr_t       m_pc;
  logic         m_btb_v [NR_ROWS][INSTR_PER_FETCH];
  vaddr_t       m_btb_t [NR_ROWS][INSTR_PER_FETCH];
  logic [1:0]   m_cnt   [NR_ROWS][INSTR_PER_FETCH];

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  bp_frontend u_bp_frontend (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .fetch_en_i   (fetch_en_i),
    .flush_i      (flush_i),
    .debug_mode_i (debug_mode_i),
    .resolve_i    (resolve_i),
    .fetch_req_o  (fetch_req_o)
  );

  // Failures counted by the bound checker
  int unsigned assert_fails;
  assign assert_fails = u_bp_frontend.u_next_pc_ctrl.u_bp_frontend_assertions.fail_count;

  // A concurrent assertion failure ends the run at the next falling edge
  always @(negedge clk_i) begin
    if (assert_fails != 0) begin
      $display("A concurrent assertion in the control block failed");
      fail_run();
    end
  end

  // Valid bits off and counters weakly not-taken
  task automatic clear_tables();
    for (int r = 0; r < NR_ROWS; r++) begin
      for (int s = 0; s < INSTR_PER_FETCH; s++) begin
        m_btb_v[r][s] = 1'b0;
        m_cnt[r][s]   = 2'b01;
      end
    end
  endtask

  // First valid and taken slot at or after PC bit 1 in the row of PC bits 4:2
  function automatic void model_lookup(output logic hit, output vaddr_t target);
    int row;
    row    = int'(m_pc[4:2]);
    hit    = 1'b0;
    target = {m_pc[VLEN-1:2], 2'b00} + 32'd4;
    for (int s = int'(m_pc[1]); s < INSTR_PER_FETCH; s++) begin
      if (!hit && m_btb_v[row][s] && m_cnt[row][s][1]) begin
        hit    = 1'b1;
        target = m_btb_t[row][s];
      end
    end
  endfunction

  function automatic fetch_req_t model_fetch(input resolution_t res);
    fetch_req_t exp;
    logic       hit;
    vaddr_t     target;
    model_lookup(hit, target);
    exp.valid      = (m_state == ST_FETCH);
    exp.pc         = m_pc;
    // A redirect in this cycle overrides the prediction
    exp.pred_taken = exp.valid && hit && !(res.valid && res.mispredict);
    return exp;
  endfunction

  task automatic model_advance(input logic en, input logic fl, input logic dbg,
                               input resolution_t res);
    logic   mis;
    logic   hit;
    vaddr_t target;
    int     row;
    int     slot;
    mis  = res.valid && res.mispredict;
    row  = int'(res.pc[4:2]);
    slot = int'(res.pc[1]);
    model_lookup(hit, target);
    boot_check = 1'b0;
    // Redirect, then flush, then predicted or sequential PC
    if (m_state == ST_FETCH && mis) begin
      m_pc = res.taken ? res.target : res.pc + 32'd2;
    end else if (fl) begin
      m_pc       = BOOT_ADDR;
      boot_check = 1'b1;
    end else if (m_state == ST_FETCH && en) begin
      m_pc = target;
    end
    m_state = en ? ST_FETCH : ST_IDLE;
    if (fl) begin
      clear_tables();
    end else begin
      if (mis && res.taken && !dbg) begin
        m_btb_v[row][slot] = 1'b1;
        m_btb_t[row][slot] = res.target;
      end
      if (res.valid && !dbg) begin
        if (res.kind == CF_JUMP) begin
          m_cnt[row][slot] = 2'b11;
        end else if (res.taken && m_cnt[row][slot] != 2'b11) begin
          m_cnt[row][slot] = m_cnt[row][slot] + 2'd1;
        end else if (!res.taken && m_cnt[row][slot] != 2'b00) begin
          m_cnt[row][slot] = m_cnt[row][slot] - 2'd1;
        end
      end
    end
  endtask

  // ------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------
  task automatic fail_run();
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_fetch(input string name, input fetch_req_t exp, input fetch_req_t act);
    if (act !== exp) begin
      $write("Error %s: expected valid=%0b pc=%h pred_taken=%0b, ",
             name, exp.valid, exp.pc, exp.pred_taken);
      $display("actual valid=%0b pc=%h pred_taken=%0b",
               act.valid, act.pc, act.pred_taken);
      fail_run();
    end
  endtask

  task automatic check_pc(input string name, input vaddr_t exp, input vaddr_t act);
    if (act !== exp) begin
      $display("Error %s: expected pc=%h, actual pc=%h", name, exp, act);
      fail_run();
    end
  endtask

  // Resolutions inside a 64-byte window so rows alias
  function automatic resolution_t random_resolution();
    resolution_t res;
    logic [31:0] r;
    r              = $random(seed);
    res.valid      = (r[2:0] < 3'd3);
    res.mispredict = r[3] & r[4];
    res.taken      = (r[7:5] >= 3'd3);
    res.kind       = (r[9:8] == 2'b11) ? CF_JUMP : CF_BRANCH;
    res.pc         = BOOT_ADDR | vaddr_t'({r[14:10], 1'b0});
    res.target     = BOOT_ADDR | vaddr_t'({r[19:15], 1'b0});
    return res;
  endfunction

  // Drive 1 ns after the edge and check mid-cycle before the model advances
  task automatic run_cycle(input logic en, input logic fl, input logic dbg,
                           input resolution_t res);
    fetch_req_t exp;
    fetch_en_i   = en;
    flush_i      = fl;
    debug_mode_i = dbg;
    resolve_i    = res;
    @(negedge clk_i);
    if (boot_check) begin
      check_pc("boot_pc_after_flush", BOOT_ADDR, fetch_req_o.pc);
    end
    exp = model_fetch(res);
    check_fetch("fetch_cycle", exp, fetch_req_o);
    @(posedge clk_i);
    model_advance(en, fl, dbg, res);
    #1;
  endtask

  initial begin
    logic [31:0] r;
    resolution_t no_res;
    logic        dbg;
    int          waited;
    seed         = 32'hc2f6;
    boot_check   = 1'b0;
    no_res       = '0;
    dbg          = 1'b0;
    rst_ni       = 1'b0;
    fetch_en_i   = 1'b0;
    flush_i      = 1'b0;
    debug_mode_i = 1'b0;
    resolve_i    = '0;
    m_state      = ST_IDLE;
    m_pc         = BOOT_ADDR;
    clear_tables();
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    // Stays idle without enable
    repeat (3) run_cycle(1'b0, 1'b0, 1'b0, no_res);
    waited = 0;
    while (!fetch_req_o.valid) begin
      if (waited == START_TIMEOUT) begin
        $display("Fetch did not start within %0d cycles of enable", START_TIMEOUT);
        fail_run();
      end
      run_cycle(1'b1, 1'b0, 1'b0, no_res);
      waited++;
    end
    check_pc("boot_pc_after_reset", BOOT_ADDR, fetch_req_o.pc);
    // Random phase with debug mode toggling now and then
    for (int c = 0; c < NUM_CYCLES; c++) begin
      r = $random(seed);
      if (r[5:0] == 6'd0) begin
        dbg = ~dbg;
      end
      run_cycle(r[9:6] != 4'd0, r[15:10] == 6'd0, dbg, random_resolution());
    end
    if (assert_fails == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("A concurrent assertion failed in the last cycle");
      fail_run();
    end
  end

endmodule

`default_nettype wire
